// ==== src/cpu_pkg.sv ====
////////////////////
// shared definitions for the 16-bit arithmetic datapath
// widths follow the instruction format, opcodes keep their
// fixed encoding, and the stage records travel as packed
// structs between decoder, register bank and execute stage
////////////////////

package cpu_pkg;

	localparam int DATA_W = 16;
	localparam int REG_AW = 3;
	localparam int OPC_W  = 4;
	localparam int IMM_W  = 9;

	// eight general registers
	localparam int NUM_REGS = 1 << REG_AW;

	// bits left over in the register-register format
	localparam int PAD_W = DATA_W - OPC_W - 2 * REG_AW;

	typedef enum logic [OPC_W-1:0] {
		OP_ADD   = 4'b0000,
		OP_SUB   = 4'b0001,
		OP_AND   = 4'b0010,
		OP_OR    = 4'b0011,
		OP_MOVI  = 4'b0100,
		OP_XOR   = 4'b0101,
		OP_MINUS = 4'b1000
	} opcode_e;

	// rd <- rd op rs
	typedef struct packed {
		logic [OPC_W-1:0]  opcode;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs;
		logic [PAD_W-1:0]  unused;
	} alu_fmt_t;

	// rd <- zero-extended constant
	typedef struct packed {
		logic [OPC_W-1:0]  opcode;
		logic [REG_AW-1:0] rd;
		logic [IMM_W-1:0]  imm;
	} imm_fmt_t;

	typedef union packed {
		alu_fmt_t alu;
		imm_fmt_t imm;
	} instr_u;

	typedef struct packed {
		logic              valid;
		opcode_e           op;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs;
		logic [DATA_W-1:0] imm;
	} dec_op_t;

	typedef struct packed {
		logic z;
		logic m;
		logic o;
		logic c;
	} flags_t;

	typedef struct packed {
		logic              en;
		logic [REG_AW-1:0] addr;
		logic [DATA_W-1:0] data;
	} wb_t;

	typedef struct packed {
		logic [REG_AW-1:0] rd;
		logic [DATA_W-1:0] data;
		flags_t            flags;
	} result_t;

endpackage

// ==== src/instr_decoder.sv ====
////////////////////
// first stage of the datapath
// samples an instruction word on its valid strobe and
// registers one decoded operation record for execute
// opcodes outside the kept set never become valid
////////////////////

`timescale 1ns/1ns

module instr_decoder
	import cpu_pkg::*;
(
	input  logic    Clock,
	input  logic    rst_n_i,
	input  logic    instr_valid_i,
	input  instr_u  instr_i,
	output dec_op_t dec_op_o
);

	logic    known_op;
	dec_op_t dec_next;

	// only the seven arithmetic and move opcodes are executed
	always_comb
	begin
		case (instr_i.alu.opcode)
			OP_ADD,
			OP_SUB,
			OP_AND,
			OP_OR,
			OP_MOVI,
			OP_XOR,
			OP_MINUS:
				known_op = 1'b1;
			default:
				known_op = 1'b0;
		endcase
	end

	always_comb
	begin
		dec_next.valid = instr_valid_i & known_op;
		dec_next.op    = opcode_e'(instr_i.alu.opcode);
		dec_next.rs    = instr_i.alu.rs;
		dec_next.rd    = instr_i.alu.rd;
		dec_next.imm   = {{(DATA_W - IMM_W){1'b0}}, instr_i.imm.imm};
	end

	always_ff @(posedge Clock or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			dec_op_o <= '0;
		end
		else
		begin
			dec_op_o.valid <= dec_next.valid;
			// hold the last record between instructions
			if (dec_next.valid)
			begin
				dec_op_o.op  <= dec_next.op;
				dec_op_o.rd  <= dec_next.rd;
				dec_op_o.rs  <= dec_next.rs;
				dec_op_o.imm <= dec_next.imm;
			end
		end
	end

endmodule

// ==== src/reg_bank.sv ====
////////////////////
// general register bank, eight 16-bit entries
// two combinational read ports addressed by the decoded
// rd and rs fields, one write port driven by execute
////////////////////

`timescale 1ns/1ns

module reg_bank
	import cpu_pkg::*;
(
	input  logic              Clock,
	input  logic              rst_n_i,
	input  logic [REG_AW-1:0] rd_addr_i,
	input  logic [REG_AW-1:0] rs_addr_i,
	input  wb_t               wb_i,
	output logic [DATA_W-1:0] rd_data_o,
	output logic [DATA_W-1:0] rs_data_o
);

	logic [DATA_W-1:0] regs_q [NUM_REGS];

	// write lands on the retiring edge, so the next
	// instruction already sees the new value
	always_ff @(posedge Clock or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				regs_q[i] <= '0;
			end
		end
		else
		begin
			if (wb_i.en)
			begin
				regs_q[wb_i.addr] <= wb_i.data;
			end
		end
	end

	// read ports
	assign rd_data_o = regs_q[rd_addr_i];
	assign rs_data_o = regs_q[rs_addr_i];

endmodule

// ==== src/alu_exec.sv ====
////////////////////
// execute stage of the datapath
// computes rd op rs or the move immediate, derives the
// Z M O C flags, writes the register bank and retires
// the result with its flags on the same clock edge
////////////////////

`timescale 1ns/1ns

module alu_exec
	import cpu_pkg::*;
(
	input  logic              Clock,
	input  logic              rst_n_i,
	input  dec_op_t           dec_op_i,
	input  logic [DATA_W-1:0] rd_data_i,
	input  logic [DATA_W-1:0] rs_data_i,
	output wb_t               wb_o,
	output logic              res_valid_o,
	output result_t           res_o
);

	logic              sub_sel;
	logic              carry_sel;
	logic [DATA_W-1:0] b_eff;
	logic [DATA_W-1:0] low_sum;
	logic [1:0]        top_sum;
	logic [DATA_W-1:0] adder_out;
	logic              carry_hi;
	logic              carry_lo;
	logic [DATA_W-1:0] alu_res;
	flags_t            flags_next;

	logic [REG_AW-1:0] res_rd_q;
	logic [DATA_W-1:0] res_data_q;
	flags_t            flags_q;

	// SUB and MINUS both go through a + ~b + 1
	assign sub_sel = (dec_op_i.op == OP_SUB) || (dec_op_i.op == OP_MINUS);

	// carry and overflow are only reported for ADD and SUB
	assign carry_sel = (dec_op_i.op == OP_ADD) || (dec_op_i.op == OP_SUB);

	assign b_eff = sub_sel ? ~rs_data_i : rs_data_i;

	// adder split at bit 14 so both top carries are visible
	always_comb
	begin
		low_sum = {1'b0, rd_data_i[DATA_W-2:0]}
			+ {1'b0, b_eff[DATA_W-2:0]}
			+ {{(DATA_W-1){1'b0}}, sub_sel};
		top_sum = {1'b0, rd_data_i[DATA_W-1]}
			+ {1'b0, b_eff[DATA_W-1]}
			+ {1'b0, low_sum[DATA_W-1]};
		adder_out = {top_sum[0], low_sum[DATA_W-2:0]};
		carry_lo  = low_sum[DATA_W-1];
		carry_hi  = top_sum[1];
	end

	always_comb
	begin
		case (dec_op_i.op)
			OP_ADD,
			OP_SUB,
			OP_MINUS:
				alu_res = adder_out;
			OP_AND:
				alu_res = rd_data_i & rs_data_i;
			OP_OR:
				alu_res = rd_data_i | rs_data_i;
			OP_XOR:
				alu_res = rd_data_i ^ rs_data_i;
			OP_MOVI:
				alu_res = dec_op_i.imm;
			default:
				alu_res = '0;
		endcase
	end

	always_comb
	begin
		flags_next.z = (alu_res == '0);
		flags_next.m = alu_res[DATA_W-1];
		// signed overflow when the two top carries disagree
		flags_next.o = carry_sel & (carry_hi ^ carry_lo);
		flags_next.c = carry_sel & carry_hi;
	end

	// write-back happens on the edge that retires the instruction
	assign wb_o.en   = dec_op_i.valid;
	assign wb_o.addr = dec_op_i.rd;
	assign wb_o.data = alu_res;

	always_ff @(posedge Clock or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			res_valid_o <= 1'b0;
			res_rd_q    <= '0;
			res_data_q  <= '0;
			flags_q     <= '0;
		end
		else
		begin
			res_valid_o <= dec_op_i.valid;
			if (dec_op_i.valid)
			begin
				res_rd_q   <= dec_op_i.rd;
				res_data_q <= alu_res;
				flags_q    <= flags_next;
			end
		end
	end

	// the flag flip-flops are shown directly with the result
	assign res_o.rd    = res_rd_q;
	assign res_o.data  = res_data_q;
	assign res_o.flags = flags_q;

endmodule

// ==== src/datapath_top.sv ====
////////////////////
// top level of the 16-bit arithmetic datapath
// decoder feeds the register bank read ports and the
// execute stage, which writes back and reports results
// a result pulse follows two edges after the strobe
////////////////////

`timescale 1ns/1ns

module datapath_top
	import cpu_pkg::*;
(
	input  logic    Clock,
	input  logic    rst_n_i,
	input  logic    instr_valid_i,
	input  instr_u  instr_i,
	output logic    res_valid_o,
	output result_t res_o
);

	dec_op_t           dec_op;
	logic [DATA_W-1:0] rd_data;
	logic [DATA_W-1:0] rs_data;
	wb_t               wb;

	instr_decoder u_instr_decoder (
		.Clock         (Clock),
		.rst_n_i       (rst_n_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.dec_op_o      (dec_op)
	);

	// operands are addressed straight from the decoded record
	reg_bank u_reg_bank (
		.Clock     (Clock),
		.rst_n_i   (rst_n_i),
		.rd_addr_i (dec_op.rd),
		.rs_addr_i (dec_op.rs),
		.wb_i      (wb),
		.rd_data_o (rd_data),
		.rs_data_o (rs_data)
	);

	alu_exec u_alu_exec (
		.Clock       (Clock),
		.rst_n_i     (rst_n_i),
		.dec_op_i    (dec_op),
		.rd_data_i   (rd_data),
		.rs_data_i   (rs_data),
		.wb_o        (wb),
		.res_valid_o (res_valid_o),
		.res_o       (res_o)
	);

endmodule

// ==== sim/datapath_props.sv ====
////////////////////
// concurrent checks on the datapath ports
// bound into every datapath_top instance
////////////////////

`timescale 1ns/1ns

module datapath_props
	import cpu_pkg::*;
(
	input logic    Clock,
	input logic    rst_n_i,
	input logic    instr_valid_i,
	input logic    res_valid_o,
	input result_t res_o
);

	// nothing retires while reset is held
	a_quiet_in_reset: assert property (@(posedge Clock) !rst_n_i |-> !res_valid_o)
		else $error("result pulse while reset is asserted");

	// every pulse traces back to a strobe two edges earlier
	a_pulse_has_strobe: assert property (@(posedge Clock) disable iff (!rst_n_i)
		res_valid_o |-> $past(instr_valid_i, 2))
		else $error("result pulse without a matching strobe");

	a_zero_minus_flags: assert property (@(posedge Clock) disable iff (!rst_n_i)
		res_valid_o |-> (res_o.flags.z == (res_o.data == '0))
			&& (res_o.flags.m == res_o.data[DATA_W-1]))
		else $error("Z or M flag does not follow the result data");

endmodule

bind datapath_top datapath_props u_datapath_props (
	.Clock         (Clock),
	.rst_n_i       (rst_n_i),
	.instr_valid_i (instr_valid_i),
	.res_valid_o   (res_valid_o),
	.res_o         (res_o)
);

// ==== sim/tb_datapath.sv ====
////////////////////
// testbench for the 16-bit arithmetic datapath
// drives instruction words on the falling edge, predicts
// each result with a register model and compares every
// result pulse against it, with a watchdog on the run
////////////////////

`timescale 1ns/1ns

module tb_datapath
	import cpu_pkg::*;
();

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 16;
	// upper bound on issued words, idle cycles come on top
	localparam int MAX_INSTR    = 200;
	localparam int TIMEOUT_NS   = (RESET_CYCLES + 4 * MAX_INSTR) * CLK_PERIOD + 400;

	localparam opcode_e LOGIC_OPS [4] = '{OP_AND, OP_OR, OP_XOR, OP_MINUS};
	localparam opcode_e ALL_OPS [7] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_MOVI, OP_XOR, OP_MINUS};

	logic    Clock;
	logic    rst_n_i;
	logic    instr_valid_i;
	instr_u  instr_i;
	logic    res_valid_o;
	result_t res_o;

	integer            seed = 32'hd17d10b4;
	logic [DATA_W-1:0] model_regs [NUM_REGS];
	result_t           exp_q [$];
	int                edge_q [$];
	int                edge_cnt = 0;
	int                data_errs = 0;
	int                flag_errs = 0;
	int                other_errs = 0;
	int                stim_errs = 0;

	datapath_top u_datapath_top (
		.Clock         (Clock),
		.rst_n_i       (rst_n_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.res_valid_o   (res_valid_o),
		.res_o         (res_o)
	);

	initial
	begin
		Clock = 1'b0;
		forever #(CLK_PERIOD / 2) Clock = ~Clock;
	end

	function automatic logic is_known(input logic [OPC_W-1:0] op);
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_MOVI, OP_XOR, OP_MINUS:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic instr_u alu_word(input logic [OPC_W-1:0] op,
		input logic [REG_AW-1:0] rd, input logic [REG_AW-1:0] rs);
		instr_u w;
		w = '0;
		w.alu.opcode = op;
		w.alu.rd     = rd;
		w.alu.rs     = rs;
		return w;
	endfunction

	function automatic instr_u movi_word(input logic [REG_AW-1:0] rd,
		input logic [IMM_W-1:0] imm);
		instr_u w;
		w.imm.opcode = OP_MOVI;
		w.imm.rd     = rd;
		w.imm.imm    = imm;
		return w;
	endfunction

	// reference model that updates the model registers as it goes
	function automatic result_t model_exec(input instr_u w);
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] r;
		logic [DATA_W:0]   wide;
		result_t           res;
		a   = model_regs[w.alu.rd];
		b   = model_regs[w.alu.rs];
		res = '0;
		case (w.alu.opcode)
			OP_ADD:
			begin
				wide = {1'b0, a} + {1'b0, b};
				r = wide[DATA_W-1:0];
				res.flags.c = wide[DATA_W];
				// like signs in, opposite sign out
				res.flags.o = (a[DATA_W-1] == b[DATA_W-1]) && (r[DATA_W-1] != a[DATA_W-1]);
			end
			OP_SUB:
			begin
				wide = {1'b0, a} + {1'b0, ~b} + 17'd1;
				r = wide[DATA_W-1:0];
				res.flags.c = wide[DATA_W];
				res.flags.o = (a[DATA_W-1] != b[DATA_W-1]) && (r[DATA_W-1] != a[DATA_W-1]);
			end
			OP_MINUS: r = a - b;
			OP_AND:   r = a & b;
			OP_OR:    r = a | b;
			OP_XOR:   r = a ^ b;
			OP_MOVI:  r = {{(DATA_W - IMM_W){1'b0}}, w.imm.imm};
			default:  r = '0;
		endcase
		res.flags.z = (r == '0);
		res.flags.m = r[DATA_W-1];
		res.rd      = w.alu.rd;
		res.data    = r;
		model_regs[w.alu.rd] = r;
		return res;
	endfunction

	task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] want,
		input string name);
		if (got !== want)
		begin
			data_errs++;
			$display("Error: time %0t %s got %h expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_flags(input flags_t got, input flags_t want);
		if (got !== want)
		begin
			flag_errs++;
			$display("Error: time %0t res_o.flags (zmoc) got %b expected %b", $time, got, want);
		end
	endtask

	task automatic reset_model();
		for (int i = 0; i < NUM_REGS; i++)
		begin
			model_regs[i] = '0;
		end
	endtask

	task automatic issue(input instr_u w);
		@(negedge Clock);
		instr_valid_i = 1'b1;
		instr_i       = w;
		if (is_known(w.alu.opcode))
		begin
			exp_q.push_back(model_exec(w));
			edge_q.push_back(edge_cnt + 1);
		end
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(negedge Clock);
			instr_valid_i = 1'b0;
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		idle(1);
		while (exp_q.size() != 0 && waited < 8)
		begin
			idle(1);
			waited++;
		end
		if (exp_q.size() != 0)
		begin
			stim_errs++;
			$display("%0d expected results never arrived by time %0t", exp_q.size(), $time);
		end
	endtask

	always @(posedge Clock)
	begin : compare_results
		result_t want;
		int      issued;
		edge_cnt = edge_cnt + 1;
		// words in flight are lost when reset hits
		if (!rst_n_i)
		begin
			exp_q.delete();
			edge_q.delete();
		end
		if (res_valid_o)
		begin
			if (exp_q.size() == 0)
			begin
				other_errs++;
				$display("unexpected result pulse at time %0t with nothing outstanding", $time);
			end
			else
			begin
				want   = exp_q.pop_front();
				issued = edge_q.pop_front();
				if (edge_cnt != issued + 2)
				begin
					other_errs++;
					$display("result at time %0t came %0d edges after its strobe instead of 2",
						$time, edge_cnt - issued);
				end
				if (res_o.rd !== want.rd)
				begin
					other_errs++;
					$display("Error: time %0t res_o.rd got %0d expected %0d", $time, res_o.rd,
						want.rd);
				end
				check_data(res_o.data, want.data, "res_o.data");
				check_flags(res_o.flags, want.flags);
			end
		end
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin : stimulus
		logic [31:0]       rnd;
		instr_u            w;
		logic [2:0]        idx;
		rst_n_i       = 1'b0;
		instr_valid_i = 1'b0;
		instr_i       = '0;
		reset_model();
		repeat (RESET_CYCLES) @(negedge Clock);
		rst_n_i = 1'b1;

		// load every register with a constant
		for (int i = 0; i < NUM_REGS; i++)
		begin
			rnd = $random(seed);
			issue(movi_word(i[REG_AW-1:0], rnd[IMM_W-1:0]));
		end
		drain();

		// carry and signed overflow corners
		issue(movi_word(3'd1, 9'h000));
		issue(movi_word(3'd2, 9'h001));
		issue(alu_word(OP_SUB, 3'd1, 3'd2));
		issue(movi_word(3'd3, 9'h001));
		issue(alu_word(OP_ADD, 3'd3, 3'd1));
		issue(alu_word(OP_SUB, 3'd2, 3'd2));
		issue(movi_word(3'd4, 9'h100));
		// doubling reaches 16'h8000 with overflow, then wraps to zero
		repeat (8) issue(alu_word(OP_ADD, 3'd4, 3'd4));
		issue(movi_word(3'd5, 9'h001));
		issue(movi_word(3'd6, 9'h100));
		repeat (7) issue(alu_word(OP_ADD, 3'd6, 3'd6));
		issue(alu_word(OP_SUB, 3'd5, 3'd6));
		issue(alu_word(OP_SUB, 3'd6, 3'd5));
		drain();

		// logic ops and minus on random registers with some gaps
		for (int i = 0; i < 40; i++)
		begin
			rnd = $random(seed);
			issue(alu_word(LOGIC_OPS[rnd[1:0]], rnd[4:2], rnd[7:5]));
			if (rnd[8])
			begin
				idle(1);
			end
		end
		drain();

		// dependent chain on r7 with the strobe high every cycle
		for (int i = 0; i < 24; i++)
		begin
			rnd = $random(seed);
			idx = 3'(rnd[15:0] % 16'd7);
			w = rnd[31:16];
			w.alu.opcode = ALL_OPS[idx];
			w.alu.rd     = 3'd7;
			issue(w);
		end
		drain();

		// unknown opcodes mixed in, then read every register back
		for (int i = 0; i < 24; i++)
		begin
			rnd = $random(seed);
			w = rnd[15:0];
			if (rnd[16])
			begin
				w.alu.opcode = {1'b1, rnd[19:17] | 3'b001};
			end
			issue(w);
		end
		for (int i = 0; i < NUM_REGS; i++)
		begin
			issue(alu_word(OP_OR, i[REG_AW-1:0], i[REG_AW-1:0]));
		end
		drain();

		// reset with words in flight and the strobe still high
		for (int i = 0; i < 4; i++)
		begin
			rnd = $random(seed);
			issue(alu_word(OP_ADD, rnd[2:0], rnd[5:3]));
		end
		@(negedge Clock);
		rst_n_i = 1'b0;
		reset_model();
		repeat (4)
		begin
			rnd = $random(seed);
			instr_i = alu_word(OP_XOR, rnd[2:0], rnd[5:3]);
			@(negedge Clock);
		end
		instr_valid_i = 1'b0;
		rst_n_i       = 1'b1;
		for (int i = 0; i < NUM_REGS; i++)
		begin
			issue(alu_word(OP_ADD, i[REG_AW-1:0], i[REG_AW-1:0]));
		end
		drain();

		idle(2);
		$display("errors: data %0d, flags %0d, other %0d, stimulus %0d",
			data_errs, flag_errs, other_errs, stim_errs);
		if (data_errs + flag_errs + other_errs + stim_errs == 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
src/cpu_pkg.sv
src/instr_decoder.sv
src/reg_bank.sv
src/alu_exec.sv
src/datapath_top.sv
sim/datapath_props.sv
sim/tb_datapath.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_datapath
FILELIST  := verilog.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := TEST FAILED
PASS_MSG  := TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
